//--- src/cachePkg.sv
package cachePkg;

  // address and line geometry
  localparam int addrBits = 31;
  localparam int tagBits = 21;
  localparam int lineIndexBits = 7;
  localparam int wordOffsetBits = 3;
  localparam int wordsPerLine = 8;
  localparam int cacheAddrBits = lineIndexBits + wordOffsetBits;

  // source ids and slot types share this width
  localparam int sourceBits = 4;

  // ring slot types
  localparam logic [sourceBits-1:0] slotNull = 4'd7;
  localparam logic [sourceBits-1:0] slotToken = 4'd1;
  localparam logic [sourceBits-1:0] slotAddress = 4'd2;
  localparam logic [sourceBits-1:0] slotWriteData = 4'd3;
  localparam logic [sourceBits-1:0] slotGrantExclusive = 4'd6;

  // line states
  localparam logic [1:0] stateInvalid = 2'd0;
  localparam logic [1:0] stateShared = 2'd1;
  localparam logic [1:0] stateModified = 2'd3;

  // address slot layout, flags from the top down
  typedef struct packed {
    logic reserved;
    logic noData;
    // exclusive on a read request, requested flush on a flush
    logic exclusive;
    logic read;
    logic [tagBits-1:0] tag;
    logic [lineIndexBits-1:0] line;
  } addressView_t;

  // one ring word, read through the view the slot type selects
  typedef union packed {
    addressView_t address;
    logic [31:0] data;
  } ringWord_t;

endpackage

//--- src/tagStatusArray.sv
`timescale 1ns/1ps

module tagStatusArray import cachePkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic [lineIndexBits-1:0] reqLine,
  output logic [tagBits-1:0] reqTag,
  output logic [1:0] reqState,
  input  logic tagWrite,
  input  logic stateWrite,
  input  logic [tagBits-1:0] newTag,
  input  logic [1:0] newState,
  input  logic [lineIndexBits-1:0] ringLine,
  output logic [tagBits-1:0] ringTag,
  output logic [1:0] ringState
);

  localparam int lineCount = 2 ** lineIndexBits;

  logic [tagBits-1:0] tagMem [lineCount];
  logic [1:0] stateMem [lineCount];

  // CPU side lookup
  assign reqTag = tagMem[reqLine];
  assign reqState = stateMem[reqLine];

  // ring side lookup for the snoop filter
  assign ringTag = tagMem[ringLine];
  assign ringState = stateMem[ringLine];

  always_ff @(posedge clock) begin
    if (tagWrite) begin
      tagMem[reqLine] <= newTag;
    end
  end

  // every line starts out Invalid
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < lineCount; i++) begin
        stateMem[i] <= stateInvalid;
      end
    end else if (stateWrite) begin
      stateMem[reqLine] <= newState;
    end
  end

endmodule

//--- src/dataArray.sv
`timescale 1ns/1ps

module dataArray import cachePkg::*; (
  input  logic clock,
  input  logic [cacheAddrBits-1:0] portAddr,
  input  logic portWrite,
  input  logic [31:0] portData,
  output logic [31:0] readData,
  input  logic fillWrite,
  input  logic [cacheAddrBits-1:0] fillAddr,
  input  logic [31:0] fillData
);

  localparam int wordCount = 2 ** cacheAddrBits;

  logic [31:0] mem [wordCount];

  always_ff @(posedge clock) begin
    // read returns the word as it was before this edge
    readData <= mem[portAddr];
    if (portWrite) begin
      mem[portAddr] <= portData;
    end
    // refill words from the read-return bus
    if (fillWrite) begin
      mem[fillAddr] <= fillData;
    end
  end

endmodule

//--- src/snoopQueue.sv
`timescale 1ns/1ps

module snoopQueue import cachePkg::*; #(
  parameter logic [sourceBits-1:0] coreId = 4'd1
) (
  input  logic clock,
  input  logic reset,
  input  logic [31:0] ringIn,
  input  logic [sourceBits-1:0] slotTypeIn,
  input  logic [sourceBits-1:0] sourceIn,
  input  logic [tagBits-1:0] ringTag,
  input  logic [1:0] ringState,
  input  logic snoopTake,
  output logic snoopValid,
  output ringWord_t snoopWord
);

  localparam int depth = 4;

  ringWord_t slot;
  ringWord_t entries [depth];
  logic [1:0] writePtr;
  logic [1:0] readPtr;
  logic [2:0] count;
  logic lineHit;
  logic snoopHit;
  logic full;
  logic capture;
  logic pop;

  assign slot = ringIn;

  // another core's address slot on a line we hold
  assign lineHit = (slotTypeIn == slotAddress) && (sourceIn != coreId) &&
                   (ringState != stateInvalid) && (ringTag == slot.address.tag);

  // exclusive request, or a plain read of a dirty line
  assign snoopHit = lineHit && slot.address.read &&
                    (slot.address.exclusive || ringState == stateModified);

  assign full = (count == 3'(depth));
  // a snoop that arrives while full is dropped
  assign capture = snoopHit && !full;
  assign pop = snoopTake && snoopValid;

  assign snoopValid = (count != 3'd0);
  assign snoopWord = entries[readPtr];

  always_ff @(posedge clock) begin
    if (capture) begin
      entries[writePtr] <= slot;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= 2'd0;
      readPtr <= 2'd0;
      count <= 3'd0;
    end else begin
      if (capture) begin
        writePtr <= writePtr + 2'd1;
      end
      if (pop) begin
        readPtr <= readPtr + 2'd1;
      end
      case ({capture, pop})
        2'b10: count <= count + 3'd1;
        2'b01: count <= count - 3'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/refillTracker.sv
`timescale 1ns/1ps

module refillTracker import cachePkg::*; #(
  parameter logic [sourceBits-1:0] coreId = 4'd1
) (
  input  logic clock,
  input  logic reset,
  input  logic startFill,
  input  logic noData,
  input  logic [sourceBits-1:0] rdDest,
  input  logic [sourceBits-1:0] slotTypeIn,
  input  logic [sourceBits-1:0] sourceIn,
  output logic fillWrite,
  output logic [wordOffsetBits-1:0] fillOffset,
  output logic fillDone
);

  logic active;
  logic upgradeOnly;
  logic [wordOffsetBits-1:0] wordCount;
  logic lastWord;
  logic grantSeen;

  // words only land for a request that asked for data
  assign fillWrite = active && !upgradeOnly && (rdDest == coreId);
  assign fillOffset = wordCount;
  assign lastWord = fillWrite && (wordCount == wordOffsetBits'(wordsPerLine - 1));
  assign grantSeen = active && upgradeOnly && (slotTypeIn == slotGrantExclusive) &&
                     (sourceIn == coreId);

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      upgradeOnly <= 1'b0;
      wordCount <= '0;
      fillDone <= 1'b0;
    end else begin
      // pulse one cycle after the closing word or grant
      fillDone <= lastWord || grantSeen;
      if (startFill) begin
        active <= 1'b1;
        upgradeOnly <= noData;
        wordCount <= '0;
      end else begin
        if (lastWord || grantSeen) begin
          active <= 1'b0;
        end
        if (fillWrite) begin
          wordCount <= wordCount + 1'b1;
        end
      end
    end
  end

endmodule

//--- src/cacheController.sv
`timescale 1ns/1ps

module cacheController import cachePkg::*; #(
  parameter logic [sourceBits-1:0] coreId = 4'd1
) (
  input  logic clock,
  input  logic reset,
  input  logic [addrBits-1:0] aq,
  input  logic read,
  input  logic selDCache,
  input  logic [tagBits-1:0] reqTag,
  input  logic [1:0] reqState,
  input  logic [31:0] readData,
  input  logic snoopValid,
  input  ringWord_t snoopWord,
  input  logic fillDone,
  input  logic [31:0] ringIn,
  input  logic [sourceBits-1:0] slotTypeIn,
  input  logic [sourceBits-1:0] sourceIn,
  input  logic dcAcquireToken,
  output logic [lineIndexBits-1:0] reqLine,
  output logic tagWrite,
  output logic stateWrite,
  output logic [tagBits-1:0] newTag,
  output logic [1:0] newState,
  output logic [cacheAddrBits-1:0] portAddr,
  output logic portWrite,
  output logic startFill,
  output logic noData,
  output logic snoopTake,
  output logic done,
  output logic wrq,
  output logic rwq,
  output logic [31:0] ringOut,
  output logic [sourceBits-1:0] slotTypeOut,
  output logic [sourceBits-1:0] sourceOut,
  output logic dcDriveRing,
  output logic dcWantsToken
);

  localparam logic [2:0] fsmIdle = 3'd0;
  localparam logic [2:0] fsmWaitToken = 3'd1;
  localparam logic [2:0] fsmSendRequest = 3'd2;
  localparam logic [2:0] fsmFlushData = 3'd3;
  localparam logic [2:0] fsmSendFlushAddress = 3'd4;

  localparam logic [1:0] pickNone = 2'd0;
  localparam logic [1:0] pickSnoop = 2'd1;
  localparam logic [1:0] pickCpu = 2'd2;
  localparam logic [1:0] pickFill = 2'd3;

  logic [2:0] state, stateNext;
  logic [1:0] select, selectNext;
  logic doRead, doReadNext;
  logic flushNeeded, flushNeededNext;
  logic requestNoData, requestNoDataNext;
  logic missPending, missPendingNext;
  logic fillReady, fillReadyNext;
  logic [cacheAddrBits-1:0] flushAddr, flushAddrNext;
  ringWord_t flushRequest, flushRequestNext;
  ringWord_t requestWord;
  logic [tagBits-1:0] aqTag;
  logic [lineIndexBits-1:0] aqLine;
  logic tagMatch;
  logic hit;
  logic fillTaken;

  assign aqTag = aq[addrBits-1:cacheAddrBits];
  assign aqLine = aq[cacheAddrBits-1:wordOffsetBits];
  assign tagMatch = (reqTag == aqTag);
  // a write hits only on an owned line
  assign hit = tagMatch && (read ? (reqState != stateInvalid) : (reqState == stateModified));

  assign reqLine = (state == fsmIdle && select == pickSnoop) ? snoopWord.address.line : aqLine;
  assign newTag = aqTag;
  assign startFill = (state == fsmSendRequest);
  assign noData = requestNoData;
  assign dcWantsToken = (state == fsmWaitToken);
  assign dcDriveRing = (state == fsmWaitToken && dcAcquireToken) ||
                       (state == fsmSendRequest) || (state == fsmFlushData) ||
                       (state == fsmSendFlushAddress);
  assign fillTaken = (state == fsmIdle) && (select == pickFill);

  always_comb begin
    requestWord = '0;
    requestWord.address.noData = requestNoData;
    requestWord.address.exclusive = !read;
    requestWord.address.read = 1'b1;
    requestWord.address.tag = aqTag;
    requestWord.address.line = aqLine;
  end

  always_comb begin
    stateNext = state;
    doReadNext = doRead;
    flushNeededNext = flushNeeded;
    requestNoDataNext = requestNoData;
    missPendingNext = missPending;
    fillReadyNext = fillReady || fillDone;
    flushAddrNext = flushAddr;
    flushRequestNext = flushRequest;
    tagWrite = 1'b0;
    stateWrite = 1'b0;
    newState = stateInvalid;
    portWrite = 1'b0;
    snoopTake = 1'b0;
    done = 1'b0;
    wrq = 1'b0;
    rwq = 1'b0;
    ringOut = ringIn;
    slotTypeOut = slotTypeIn;
    sourceOut = sourceIn;

    case (state)
      fsmIdle: begin
        case (select)
          pickSnoop: begin
            snoopTake = 1'b1;
            // the line may have changed since the slot was queued
            if (reqState != stateInvalid && reqTag == snoopWord.address.tag) begin
              stateWrite = 1'b1;
              newState = snoopWord.address.exclusive ? stateInvalid : stateShared;
              if (reqState == stateModified) begin
                stateNext = fsmWaitToken;
                doReadNext = 1'b0;
                flushNeededNext = 1'b1;
                flushAddrNext = {snoopWord.address.line, 3'b000};
                flushRequestNext = '0;
                flushRequestNext.address.exclusive = 1'b1;
                flushRequestNext.address.tag = snoopWord.address.tag;
                flushRequestNext.address.line = snoopWord.address.line;
              end
            end
          end
          pickCpu: begin
            if (hit) begin
              done = 1'b1;
              wrq = read;
              rwq = !read;
              portWrite = !read;
            end else begin
              stateNext = fsmWaitToken;
              doReadNext = 1'b1;
              // write to a Shared copy only needs ownership
              requestNoDataNext = !read && tagMatch && (reqState == stateShared);
              flushNeededNext = (reqState == stateModified);
              missPendingNext = 1'b1;
              flushAddrNext = {aqLine, 3'b000};
              flushRequestNext = '0;
              flushRequestNext.address.tag = reqTag;
              flushRequestNext.address.line = aqLine;
              tagWrite = 1'b1;
              stateWrite = 1'b1;
              newState = read ? stateShared : stateInvalid;
            end
          end
          pickFill: begin
            fillReadyNext = fillDone;
            missPendingNext = 1'b0;
            done = 1'b1;
            wrq = read;
            rwq = !read;
            if (!read) begin
              portWrite = 1'b1;
              stateWrite = 1'b1;
              newState = stateModified;
            end
          end
          default: begin
          end
        endcase
      end
      fsmWaitToken: begin
        if (dcAcquireToken) begin
          // take the token off the ring
          ringOut = '0;
          slotTypeOut = slotNull;
          sourceOut = coreId;
          stateNext = doRead ? fsmSendRequest : fsmFlushData;
        end
      end
      fsmSendRequest: begin
        ringOut = requestWord.data;
        slotTypeOut = slotAddress;
        sourceOut = coreId;
        stateNext = flushNeeded ? fsmFlushData : fsmIdle;
      end
      fsmFlushData: begin
        ringOut = readData;
        slotTypeOut = slotWriteData;
        sourceOut = coreId;
        flushAddrNext = flushAddr + 1'b1;
        if (flushAddr[wordOffsetBits-1:0] == 3'd7) begin
          stateNext = fsmSendFlushAddress;
        end
      end
      fsmSendFlushAddress: begin
        ringOut = flushRequest.data;
        slotTypeOut = slotAddress;
        sourceOut = coreId;
        stateNext = fsmIdle;
      end
      default: begin
        stateNext = fsmIdle;
      end
    endcase

    // data port reads one word ahead during a flush
    portAddr = (stateNext == fsmIdle) ? aq[cacheAddrBits-1:0] : flushAddrNext;

    // snoops first, then a finished fill, then the CPU
    if (snoopValid && !snoopTake) begin
      selectNext = pickSnoop;
    end else if (fillReady && !fillTaken) begin
      selectNext = pickFill;
    end else if (selDCache && !done && !missPendingNext) begin
      selectNext = pickCpu;
    end else begin
      selectNext = pickNone;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fsmIdle;
      select <= pickNone;
      doRead <= 1'b0;
      flushNeeded <= 1'b0;
      requestNoData <= 1'b0;
      missPending <= 1'b0;
      fillReady <= 1'b0;
    end else begin
      state <= stateNext;
      select <= selectNext;
      doRead <= doReadNext;
      flushNeeded <= flushNeededNext;
      requestNoData <= requestNoDataNext;
      missPending <= missPendingNext;
      fillReady <= fillReadyNext;
    end
  end

  always_ff @(posedge clock) begin
    flushAddr <= flushAddrNext;
    flushRequest <= flushRequestNext;
  end

endmodule

//--- src/coherentDCache.sv
`timescale 1ns/1ps

module coherentDCache import cachePkg::*; #(
  parameter logic [sourceBits-1:0] coreId = 4'd1
) (
  input  logic clock,
  input  logic reset,
  input  logic [addrBits-1:0] aq,
  input  logic read,
  input  logic [31:0] wq,
  input  logic selDCache,
  output logic [31:0] rqDCache,
  output logic wrq,
  output logic rwq,
  output logic done,
  input  logic [31:0] ringIn,
  input  logic [sourceBits-1:0] slotTypeIn,
  input  logic [sourceBits-1:0] sourceIn,
  input  logic [31:0] rdReturn,
  input  logic [sourceBits-1:0] rdDest,
  input  logic dcAcquireToken,
  output logic [31:0] ringOut,
  output logic [sourceBits-1:0] slotTypeOut,
  output logic [sourceBits-1:0] sourceOut,
  output logic dcDriveRing,
  output logic dcWantsToken
);

  logic [lineIndexBits-1:0] reqLine;
  logic [tagBits-1:0] reqTag;
  logic [1:0] reqState;
  logic tagWrite;
  logic stateWrite;
  logic [tagBits-1:0] newTag;
  logic [1:0] newState;
  logic [tagBits-1:0] ringTag;
  logic [1:0] ringState;
  logic [cacheAddrBits-1:0] portAddr;
  logic portWrite;
  logic fillWrite;
  logic [wordOffsetBits-1:0] fillOffset;
  logic fillDone;
  logic startFill;
  logic noData;
  logic snoopValid;
  logic snoopTake;
  ringWord_t snoopWord;

  tagStatusArray tags (
    .clock(clock), .reset(reset),
    .reqLine(reqLine), .reqTag(reqTag), .reqState(reqState),
    .tagWrite(tagWrite), .stateWrite(stateWrite),
    .newTag(newTag), .newState(newState),
    .ringLine(ringIn[lineIndexBits-1:0]), .ringTag(ringTag), .ringState(ringState)
  );

  // refill words go to the line of the pending CPU request
  dataArray data (
    .clock(clock),
    .portAddr(portAddr), .portWrite(portWrite), .portData(wq), .readData(rqDCache),
    .fillWrite(fillWrite), .fillAddr({aq[cacheAddrBits-1:wordOffsetBits], fillOffset}),
    .fillData(rdReturn)
  );

  snoopQueue #(.coreId(coreId)) snoops (
    .clock(clock), .reset(reset),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .ringTag(ringTag), .ringState(ringState),
    .snoopTake(snoopTake), .snoopValid(snoopValid), .snoopWord(snoopWord)
  );

  refillTracker #(.coreId(coreId)) refill (
    .clock(clock), .reset(reset),
    .startFill(startFill), .noData(noData),
    .rdDest(rdDest), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .fillWrite(fillWrite), .fillOffset(fillOffset), .fillDone(fillDone)
  );

  cacheController #(.coreId(coreId)) control (
    .clock(clock), .reset(reset),
    .aq(aq), .read(read), .selDCache(selDCache),
    .reqTag(reqTag), .reqState(reqState), .readData(rqDCache),
    .snoopValid(snoopValid), .snoopWord(snoopWord), .fillDone(fillDone),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .dcAcquireToken(dcAcquireToken),
    .reqLine(reqLine), .tagWrite(tagWrite), .stateWrite(stateWrite),
    .newTag(newTag), .newState(newState),
    .portAddr(portAddr), .portWrite(portWrite),
    .startFill(startFill), .noData(noData), .snoopTake(snoopTake),
    .done(done), .wrq(wrq), .rwq(rwq),
    .ringOut(ringOut), .slotTypeOut(slotTypeOut), .sourceOut(sourceOut),
    .dcDriveRing(dcDriveRing), .dcWantsToken(dcWantsToken)
  );

endmodule

//--- testbench/coherentDCache_sva.sv
`timescale 1ns/1ps

module coherentDCache_sva (
  input logic clock,
  input logic reset,
  input logic done,
  input logic dcDriveRing,
  input logic dcAcquireToken,
  input logic dcWantsToken,
  input logic snoopHit,
  input logic queueFull
);

  doneSingleCycle: assert property (@(posedge clock) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // each unbroken run of driven slots starts in the cycle the token is taken
  driveStartsWithToken: assert property (@(posedge clock) disable iff (reset)
    dcDriveRing |-> (dcWantsToken && dcAcquireToken) || $past(dcDriveRing))
    else $error("ring driven without the token");

  noSnoopOverflow: assert property (@(posedge clock) disable iff (reset)
    snoopHit |-> !queueFull)
    else $error("snoop lost because the queue was full");

endmodule

bind coherentDCache coherentDCache_sva checks (
  .clock(clock), .reset(reset), .done(done),
  .dcDriveRing(dcDriveRing), .dcAcquireToken(dcAcquireToken), .dcWantsToken(dcWantsToken),
  .snoopHit(snoops.snoopHit), .queueFull(snoops.full)
);

//--- testbench/coherentDCacheTb.sv
`timescale 1ns/1ps

module coherentDCacheTb import cachePkg::*; ();

  localparam logic [sourceBits-1:0] coreId = 4'd2;
  localparam int cyclesPerTest = 200;

  logic clock = 1'b0;
  logic reset;
  logic [addrBits-1:0] aq;
  logic read;
  logic [31:0] wq;
  logic selDCache;
  logic [31:0] rqDCache;
  logic wrq, rwq, done;
  logic [31:0] ringIn, rdReturn, ringOut;
  logic [sourceBits-1:0] slotTypeIn, sourceIn, rdDest, slotTypeOut, sourceOut;
  logic dcAcquireToken, dcDriveRing, dcWantsToken;

  // memory model and ring bookkeeping
  logic [31:0] memWords [logic [addrBits-1:0]];
  logic [31:0] flushData [wordsPerLine];
  logic [31:0] lastRequest, lastFlush;
  int requestCount, flushCount, injectCount, servedCount;
  logic [31:0] injectWord;
  logic [sourceBits-1:0] injectType, injectSource;

  // tests as read from the data file
  logic [7:0] opQ[$];
  logic [31:0] addrQ[$], dataQ[$], expectQ[$];
  int errorCount;
  logic testsLoaded;

  coherentDCache #(.coreId(coreId)) dut (
    .clock(clock), .reset(reset), .aq(aq), .read(read), .wq(wq), .selDCache(selDCache),
    .rqDCache(rqDCache), .wrq(wrq), .rwq(rwq), .done(done),
    .ringIn(ringIn), .slotTypeIn(slotTypeIn), .sourceIn(sourceIn),
    .rdReturn(rdReturn), .rdDest(rdDest), .dcAcquireToken(dcAcquireToken),
    .ringOut(ringOut), .slotTypeOut(slotTypeOut), .sourceOut(sourceOut),
    .dcDriveRing(dcDriveRing), .dcWantsToken(dcWantsToken)
  );

  always #20 clock = ~clock;

  // untouched words read as their own address plus 0x10000000
  function automatic logic [31:0] readWord(input logic [addrBits-1:0] a);
    if (memWords.exists(a)) begin
      return memWords[a];
    end
    return {1'b0, a} + 32'h10000000;
  endfunction

  // ring and memory model, owns every ring-side input
  initial begin
    ringWord_t slot;
    logic [2:0] flushFill;
    logic pendingFill, pendingGrant;
    logic [addrBits-wordOffsetBits-1:0] returnBase;
    logic [3:0] returnLeft;
    logic [2:0] returnIdx;
    int tokenTimer;
    integer seed;
    seed = 32'hd0fa0218;
    flushFill = 3'd0;
    pendingFill = 1'b0;
    pendingGrant = 1'b0;
    returnBase = '0;
    returnLeft = 4'd0;
    returnIdx = 3'd0;
    tokenTimer = 0;
    requestCount = 0;
    flushCount = 0;
    servedCount = 0;
    lastRequest = '0;
    lastFlush = '0;
    ringIn = '0;
    slotTypeIn = slotNull;
    sourceIn = '0;
    rdReturn = '0;
    rdDest = '0;
    dcAcquireToken = 1'b0;
    forever begin
      @(negedge clock);
      ringIn = '0;
      slotTypeIn = slotNull;
      sourceIn = '0;
      rdReturn = '0;
      rdDest = '0;
      dcAcquireToken = 1'b0;
      if (dcDriveRing === 1'b1) begin
        slot = ringOut;
        if (slotTypeOut == slotWriteData) begin
          flushData[flushFill] = ringOut;
          flushFill = flushFill + 3'd1;
        end else if (slotTypeOut == slotAddress && slot.address.read) begin
          lastRequest = slot.data;
          requestCount++;
          pendingFill = 1'b1;
          pendingGrant = slot.address.noData;
          returnBase = {slot.address.tag, slot.address.line};
        end else if (slotTypeOut == slotAddress) begin
          // flush address closes the data slots before it
          for (logic [3:0] i = 4'd0; i < 4'd8; i++) begin
            memWords[{slot.address.tag, slot.address.line, i[2:0]}] = flushData[i[2:0]];
          end
          flushFill = 3'd0;
          lastFlush = slot.data;
          flushCount++;
        end
      end
      if (dcWantsToken === 1'b1) begin
        if (tokenTimer == 0) begin
          tokenTimer = int'($unsigned($random(seed)) % 32'd7) + 1;
        end
        tokenTimer--;
        if (tokenTimer == 0) begin
          dcAcquireToken = 1'b1;
          slotTypeIn = slotToken;
        end
      end
      if (pendingFill && dcDriveRing !== 1'b1 && returnLeft == 4'd0) begin
        pendingFill = 1'b0;
        if (pendingGrant) begin
          slotTypeIn = slotGrantExclusive;
          sourceIn = coreId;
        end else begin
          returnLeft = 4'd8;
          returnIdx = 3'd0;
        end
      end
      if (returnLeft != 4'd0) begin
        rdDest = coreId;
        rdReturn = readWord({returnBase, returnIdx});
        returnIdx = returnIdx + 3'd1;
        returnLeft = returnLeft - 4'd1;
      end else if (injectCount != servedCount && !dcAcquireToken) begin
        ringIn = injectWord;
        slotTypeIn = injectType;
        sourceIn = injectSource;
        servedCount++;
      end
    end
  end

  task automatic cpuAccess(input logic isRead, input logic [addrBits-1:0] addr,
                           input logic [31:0] data, output logic [31:0] result);
    @(negedge clock);
    aq = addr;
    read = isRead;
    wq = data;
    selDCache = 1'b1;
    @(negedge clock);
    while (done !== 1'b1) @(negedge clock);
    result = rqDCache;
    assert (wrq == isRead && rwq == !isRead) else begin
      $display("mismatch wrq/rwq: got %h/%h, expected %h/%h", wrq, rwq, isRead, !isRead);
      errorCount++;
    end
    selDCache = 1'b0;
  endtask

  // hand a slot to the ring model, which puts it on ringIn at the next falling edge
  task automatic injectSlot(input logic [31:0] word, input logic [sourceBits-1:0] kind,
                            input logic [sourceBits-1:0] source);
    @(posedge clock);
    injectWord = word;
    injectType = kind;
    injectSource = source;
    injectCount++;
    @(negedge clock);
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got == want) else begin
      $display("mismatch %s: got %h, expected %h", name, got, want);
      errorCount++;
    end
  endtask

  task automatic runTest(input int index);
    logic [7:0] op;
    logic [addrBits-1:0] addr;
    logic [31:0] data, expected, got;
    ringWord_t snoop;
    int errorsBefore, requestsBefore, flushesBefore;
    op = opQ[index];
    addr = addrQ[index][addrBits-1:0];
    data = dataQ[index];
    expected = expectQ[index];
    errorsBefore = errorCount;
    requestsBefore = requestCount;
    flushesBefore = flushCount;
    case (op)
      "R", "M": begin
        cpuAccess(1'b1, addr, 32'h0, got);
        checkWord("rqDCache", got, expected);
        if (op == "M") begin
          assert (requestCount > requestsBefore) else begin
            $display("read of %h hit, but a miss was expected", addr);
            errorCount++;
          end
        end else begin
          assert (requestCount == requestsBefore) else begin
            $display("read of %h missed, but a hit was expected", addr);
            errorCount++;
          end
        end
      end
      "W": begin
        cpuAccess(1'b0, addr, data, got);
        got = (requestCount > requestsBefore) ? lastRequest : 32'h0;
        checkWord("ringOut request", got, expected);
      end
      "S": begin
        snoop = '0;
        snoop.address.exclusive = 1'b1;
        snoop.address.read = 1'b1;
        snoop.address.tag = addr[addrBits-1:cacheAddrBits];
        snoop.address.line = addr[cacheAddrBits-1:wordOffsetBits];
        injectSlot(snoop.data, slotAddress, 4'd5);
        while (flushCount == flushesBefore) @(negedge clock);
        checkWord("ringOut flush", lastFlush, expected);
      end
      "E": checkWord("ringOut flush", lastFlush, expected);
      "P": begin
        injectSlot(data, slotWriteData, 4'd4);
        #1;
        checkWord("ringOut", ringOut, data);
        checkWord("slotTypeOut", {28'h0, slotTypeOut}, {28'h0, slotWriteData});
        checkWord("sourceOut", {28'h0, sourceOut}, 32'h4);
      end
      default: begin
        $display("unknown operation %c in test %0d", op, index);
        errorCount++;
      end
    endcase
    $display("test %0d: %c %h %s", index, op, addr, (errorCount == errorsBefore) ? "ok" : "bad");
  endtask

  initial begin
    int fd;
    int code;
    string line;
    logic [7:0] op;
    logic [31:0] addrIn, dataIn, expectIn;
    testsLoaded = 1'b0;
    errorCount = 0;
    injectCount = 0;
    injectWord = '0;
    injectType = slotNull;
    injectSource = '0;
    reset = 1'b1;
    aq = '0;
    read = 1'b0;
    wq = '0;
    selDCache = 1'b0;
    fd = $fopen("testbench/dcacheTests.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/dcacheTests.txt");
      errorCount++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%c %h %h %h", op, addrIn, dataIn, expectIn) == 4) begin
            opQ.push_back(op);
            addrQ.push_back(addrIn);
            dataQ.push_back(dataIn);
            expectQ.push_back(expectIn);
          end
        end
      end
      $fclose(fd);
    end
    if (opQ.size() == 0) begin
      $display("no tests were loaded");
      errorCount++;
    end
    testsLoaded = 1'b1;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < opQ.size(); i++) begin
      runTest(i);
    end
    repeat (4) @(negedge clock);
    $display("tests run: %0d, errors: %0d", opQ.size(), errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog sized from the number of tests
  initial begin
    wait (testsLoaded === 1'b1);
    repeat ((opQ.size() + 1) * cyclesPerTest) @(posedge clock);
    $display("timeout: tests did not finish in %0d cycles", (opQ.size() + 1) * cyclesPerTest);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- src.f
src/cachePkg.sv
src/tagStatusArray.sv
src/dataArray.sv
src/snoopQueue.sv
src/refillTracker.sv
src/cacheController.sv
src/coherentDCache.sv
testbench/coherentDCache_sva.sv
testbench/coherentDCacheTb.sv

//--- Makefile
# Verilator flow for the coherent data cache
VERILATOR ?= verilator
TOP ?= coherentDCacheTb
FILELIST ?= src.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/dcacheTests.txt
# op address data expected, all hex
# R read, M read that must miss, W write (expected request word, 0 for none)
# S snoop from source 5 (expected flush word), E last flush word, P pass-through slot
M 00000410 00000000 10000410
R 00000413 00000000 10000413
W 00000828 cafe0001 30000105
R 00000828 00000000 cafe0001
R 0000082f 00000000 1000082f
W 00000411 beef0011 70000082
R 00000411 00000000 beef0011
R 00000410 00000000 10000410
W 00000412 12340012 00000000
M 00000c10 00000000 10000c10
E 00000000 00000000 00000082
M 00000411 00000000 beef0011
R 00000412 00000000 12340012
S 00000828 00000000 20000105
M 00000828 00000000 cafe0001
P 00000000 f0f0a5a5 00000000
